//--- source/ea_defines.svh
// Effective address widths and codes
`ifndef EA_DEFINES_SVH
`define EA_DEFINES_SVH

// Datapath widths
`define EA_WORD_W 32
`define EA_HALF_W 16
`define EA_WIN_W  56
`define EA_MODE_W 3

// Address source selected for one request
`define EA_MODE_MODRM 3'd0
`define EA_MODE_ESI   3'd1
`define EA_MODE_EDI   3'd2
`define EA_MODE_XLAT  3'd3
`define EA_MODE_MOFFS 3'd4
`define EA_MODE_POP   3'd5

// Stack pop steps for 16 and 32-bit operands
`define EA_POP_STEP_16 32'd2
`define EA_POP_STEP_32 32'd4

`endif

//--- source/ea_pkg.sv
// Instruction window types
`include "ea_defines.svh"

package ea_pkg;

    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] reg_op;
        logic [2:0] rm;
    } modrm_t;

    typedef struct packed {
        logic [1:0] scale;
        logic [2:0] index;
        logic [2:0] base;
    } sib_t;

    // Opcode, ModR/M, then displacement; disp16 and disp8 are its low bits
    typedef struct packed {
        logic [7:0]            pad;
        logic [`EA_WORD_W-1:0] disp32;
        modrm_t                modrm;
        logic [7:0]            opcode;
    } modrm_form_t;

    // Displacement moves up one byte when a SIB byte is present
    typedef struct packed {
        logic [`EA_WORD_W-1:0] disp32;
        sib_t                  sib;
        modrm_t                modrm;
        logic [7:0]            opcode;
    } sib_form_t;

    // Direct offset follows the opcode, moffs16 is the low half
    typedef struct packed {
        logic [15:0]           pad;
        logic [`EA_WORD_W-1:0] moffs32;
        logic [7:0]            opcode;
    } moffs_form_t;

    typedef union packed {
        modrm_form_t as_modrm;
        sib_form_t   as_sib;
        moffs_form_t as_moffs;
    } insn_window_u;

endpackage

//--- source/ea_modrm16.sv
// 16-bit ModR/M address
`timescale 1ns/1ps
`include "ea_defines.svh"

module ea_modrm16 (
    input  ea_pkg::insn_window_u  window,
    input  logic [`EA_WORD_W-1:0] ebx,
    input  logic [`EA_WORD_W-1:0] ebp,
    input  logic [`EA_WORD_W-1:0] esi,
    input  logic [`EA_WORD_W-1:0] edi,
    output logic [`EA_HALF_W-1:0] ea16
);

    logic [1:0]            mod;
    logic [2:0]            rm;
    logic [`EA_HALF_W-1:0] disp16;
    logic [`EA_HALF_W-1:0] base;
    logic [`EA_HALF_W-1:0] disp;

    assign mod    = window.as_modrm.modrm.mod;
    assign rm     = window.as_modrm.modrm.rm;
    assign disp16 = window.as_modrm.disp32[`EA_HALF_W-1:0];

    // Register pair base
    always_comb begin
        case (rm)
            3'b000:  base = ebx[`EA_HALF_W-1:0] + esi[`EA_HALF_W-1:0];
            3'b001:  base = ebx[`EA_HALF_W-1:0] + edi[`EA_HALF_W-1:0];
            3'b010:  base = ebp[`EA_HALF_W-1:0] + esi[`EA_HALF_W-1:0];
            3'b011:  base = ebp[`EA_HALF_W-1:0] + edi[`EA_HALF_W-1:0];
            3'b100:  base = esi[`EA_HALF_W-1:0];
            3'b101:  base = edi[`EA_HALF_W-1:0];
            3'b110:  base = ebp[`EA_HALF_W-1:0];
            default: base = ebx[`EA_HALF_W-1:0];
        endcase
        case (mod)
            2'b10:   disp = disp16;
            2'b01:   disp = {{8{disp16[7]}}, disp16[7:0]};
            default: disp = '0;
        endcase
    end

    // mod=00 rm=110 is the disp16-only form, no BP base
    assign ea16 = (mod == 2'b00 && rm == 3'b110) ? disp16 : base + disp;

endmodule

//--- source/ea_sib.sv
// SIB base plus scaled index
`timescale 1ns/1ps
`include "ea_defines.svh"

module ea_sib (
    input  ea_pkg::insn_window_u  window,
    input  logic [`EA_WORD_W-1:0] eax,
    input  logic [`EA_WORD_W-1:0] ebx,
    input  logic [`EA_WORD_W-1:0] ecx,
    input  logic [`EA_WORD_W-1:0] edx,
    input  logic [`EA_WORD_W-1:0] esp,
    input  logic [`EA_WORD_W-1:0] ebp,
    input  logic [`EA_WORD_W-1:0] esi,
    input  logic [`EA_WORD_W-1:0] edi,
    output logic [`EA_WORD_W-1:0] sib_sum
);

    logic [1:0]            mod;
    ea_pkg::sib_t          sib;
    logic [`EA_WORD_W-1:0] base;
    logic [`EA_WORD_W-1:0] index;
    logic [`EA_WORD_W-1:0] index_scaled;

    assign mod = window.as_sib.modrm.mod;
    assign sib = window.as_sib.sib;

    always_comb begin
        case (sib.base)
            3'b000:  base = eax;
            3'b001:  base = ecx;
            3'b010:  base = edx;
            3'b011:  base = ebx;
            3'b100:  base = esp;
            // No base register with mod=00, disp32 takes its place
            3'b101:  base = (mod == 2'b00) ? window.as_sib.disp32 : ebp;
            3'b110:  base = esi;
            default: base = edi;
        endcase
        case (sib.index)
            3'b000:  index = eax;
            3'b001:  index = ecx;
            3'b010:  index = edx;
            3'b011:  index = ebx;
            3'b100:  index = '0;
            3'b101:  index = ebp;
            3'b110:  index = esi;
            default: index = edi;
        endcase
    end

    // Scale 1, 2, 4 or 8
    assign index_scaled = index << sib.scale;
    assign sib_sum      = base + index_scaled;

endmodule

//--- source/ea_modrm32.sv
// 32-bit ModR/M address
`timescale 1ns/1ps
`include "ea_defines.svh"

module ea_modrm32 (
    input  ea_pkg::insn_window_u  window,
    input  logic [`EA_WORD_W-1:0] eax,
    input  logic [`EA_WORD_W-1:0] ecx,
    input  logic [`EA_WORD_W-1:0] edx,
    input  logic [`EA_WORD_W-1:0] ebx,
    input  logic [`EA_WORD_W-1:0] ebp,
    input  logic [`EA_WORD_W-1:0] esi,
    input  logic [`EA_WORD_W-1:0] edi,
    input  logic [`EA_WORD_W-1:0] sib_sum,
    output logic [`EA_WORD_W-1:0] ea32
);

    logic [1:0]            mod;
    logic [2:0]            rm;
    logic [`EA_WORD_W-1:0] disp_raw;
    logic [`EA_WORD_W-1:0] base;
    logic [`EA_WORD_W-1:0] disp;

    assign mod = window.as_modrm.modrm.mod;
    assign rm  = window.as_modrm.modrm.rm;

    // rm=100 means a SIB byte sits before the displacement
    assign disp_raw = (rm == 3'b100) ? window.as_sib.disp32 : window.as_modrm.disp32;

    always_comb begin
        case (rm)
            3'b000:  base = eax;
            3'b001:  base = ecx;
            3'b010:  base = edx;
            3'b011:  base = ebx;
            3'b100:  base = sib_sum;
            3'b101:  base = ebp;
            3'b110:  base = esi;
            default: base = edi;
        endcase
        case (mod)
            2'b10:   disp = disp_raw;
            2'b01:   disp = {{(`EA_WORD_W-8){disp_raw[7]}}, disp_raw[7:0]};
            default: disp = '0;
        endcase
    end

    // Disp32-only form replaces the EBP base
    assign ea32 = (mod == 2'b00 && rm == 3'b101) ? window.as_modrm.disp32 : base + disp;

endmodule

//--- source/ea_stack_pop.sv
// Stack pop offset
`timescale 1ns/1ps
`include "ea_defines.svh"

module ea_stack_pop (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`EA_WORD_W-1:0] esp,
    input  logic [`EA_MODE_W-1:0] mode,
    input  logic                  op32,
    input  logic                  ss_big,
    input  logic                  pop_speedup,
    input  logic                  capture,
    output logic [`EA_WORD_W-1:0] pop_offset
);

    logic [`EA_WORD_W-1:0] speedup_q;
    logic [`EA_WORD_W-1:0] speedup_d;
    logic [`EA_WORD_W-1:0] esp_masked;
    logic [`EA_WORD_W-1:0] pop_start;
    logic [`EA_WORD_W-1:0] pop_step;
    logic [`EA_WORD_W-1:0] pop_sum;

    // 16-bit stack segment wraps at 64K
    function automatic logic [`EA_WORD_W-1:0] ss_mask(
        input logic                  big,
        input logic [`EA_WORD_W-1:0] value
    );
        return big ? value : {{`EA_HALF_W{1'b0}}, value[`EA_HALF_W-1:0]};
    endfunction

    assign esp_masked = ss_mask(ss_big, esp);
    assign pop_offset = pop_speedup ? speedup_q : esp_masked;

    // ---------------------------------------------------------------------
    // Next offset for a back-to-back pop
    // ---------------------------------------------------------------------
    assign pop_start = pop_speedup ? speedup_q : esp;
    assign pop_step  = op32 ? `EA_POP_STEP_32 : `EA_POP_STEP_16;
    assign pop_sum   = pop_start + pop_step;
    assign speedup_d = ss_mask(ss_big, pop_sum);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            speedup_q <= '0;
        end else if (capture && mode == `EA_MODE_POP) begin
            speedup_q <= speedup_d;
        end
    end

endmodule

//--- source/ea_result_reg.sv
// Address select and handshake
`timescale 1ns/1ps
`include "ea_defines.svh"

module ea_result_reg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    output logic                  ack,
    input  logic [`EA_MODE_W-1:0] mode,
    input  logic                  addr32,
    input  ea_pkg::insn_window_u  window,
    input  logic [`EA_WORD_W-1:0] eax,
    input  logic [`EA_WORD_W-1:0] ebx,
    input  logic [`EA_WORD_W-1:0] esi,
    input  logic [`EA_WORD_W-1:0] edi,
    input  logic [`EA_HALF_W-1:0] ea16,
    input  logic [`EA_WORD_W-1:0] ea32,
    input  logic [`EA_WORD_W-1:0] pop_offset,
    output logic                  capture,
    output logic [`EA_WORD_W-1:0] address
);

    logic [`EA_WORD_W-1:0] xlat_sum;
    logic [`EA_WORD_W-1:0] moffs32;
    logic [`EA_WORD_W-1:0] address_d;

    // Keep only the low half for 16-bit address size
    function automatic logic [`EA_WORD_W-1:0] addr_trunc(
        input logic                  wide,
        input logic [`EA_WORD_W-1:0] value
    );
        return wide ? value : {{`EA_HALF_W{1'b0}}, value[`EA_HALF_W-1:0]};
    endfunction

    // Table base plus AL
    assign xlat_sum = ebx + {{(`EA_WORD_W-8){1'b0}}, eax[7:0]};
    assign moffs32  = window.as_moffs.moffs32;

    always_comb begin
        case (mode)
            `EA_MODE_MODRM: address_d = addr32 ? ea32 : {{`EA_HALF_W{1'b0}}, ea16};
            `EA_MODE_ESI:   address_d = addr_trunc(addr32, esi);
            `EA_MODE_EDI:   address_d = addr_trunc(addr32, edi);
            `EA_MODE_XLAT:  address_d = addr_trunc(addr32, xlat_sum);
            `EA_MODE_MOFFS: address_d = addr_trunc(addr32, moffs32);
            `EA_MODE_POP:   address_d = pop_offset;
            default:        address_d = '0;
        endcase
    end

    // ---------------------------------------------------------------------
    // Four-phase req/ack
    // ---------------------------------------------------------------------
    assign capture = req && !ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack     <= 1'b0;
            address <= '0;
        end else if (capture) begin
            ack     <= 1'b1;
            address <= address_d;
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

    // ---------------------------------------------------------------------
    // Protocol checks
    // ---------------------------------------------------------------------
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req));

    mode_defined: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> mode inside {`EA_MODE_MODRM, `EA_MODE_ESI, `EA_MODE_EDI,
                             `EA_MODE_XLAT, `EA_MODE_MOFFS, `EA_MODE_POP});

    // Held result must not move while the requester waits
    address_held: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && req && $past(ack) && $past(req)) |-> $stable(address));

endmodule

//--- source/read_effective_address.sv
// Effective address unit top
`timescale 1ns/1ps
`include "ea_defines.svh"

module read_effective_address (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    output logic                  ack,
    input  logic [`EA_MODE_W-1:0] mode,
    input  logic                  addr32,
    input  logic                  op32,
    input  logic                  ss_big,
    input  logic                  pop_speedup,
    input  logic [`EA_WORD_W-1:0] eax,
    input  logic [`EA_WORD_W-1:0] ebx,
    input  logic [`EA_WORD_W-1:0] ecx,
    input  logic [`EA_WORD_W-1:0] edx,
    input  logic [`EA_WORD_W-1:0] esp,
    input  logic [`EA_WORD_W-1:0] ebp,
    input  logic [`EA_WORD_W-1:0] esi,
    input  logic [`EA_WORD_W-1:0] edi,
    input  ea_pkg::insn_window_u  window,
    output logic [`EA_WORD_W-1:0] address
);

    logic [`EA_WORD_W-1:0] sib_sum;
    logic [`EA_HALF_W-1:0] ea16;
    logic [`EA_WORD_W-1:0] ea32;
    logic [`EA_WORD_W-1:0] pop_offset;
    logic                  capture;

    ea_modrm16 modrm16_0 (
        .window (window),
        .ebx    (ebx),
        .ebp    (ebp),
        .esi    (esi),
        .edi    (edi),
        .ea16   (ea16)
    );

    ea_sib sib_0 (
        .window  (window),
        .eax     (eax),
        .ebx     (ebx),
        .ecx     (ecx),
        .edx     (edx),
        .esp     (esp),
        .ebp     (ebp),
        .esi     (esi),
        .edi     (edi),
        .sib_sum (sib_sum)
    );

    ea_modrm32 modrm32_0 (
        .window  (window),
        .eax     (eax),
        .ecx     (ecx),
        .edx     (edx),
        .ebx     (ebx),
        .ebp     (ebp),
        .esi     (esi),
        .edi     (edi),
        .sib_sum (sib_sum),
        .ea32    (ea32)
    );

    ea_stack_pop stack_pop_0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .esp         (esp),
        .mode        (mode),
        .op32        (op32),
        .ss_big      (ss_big),
        .pop_speedup (pop_speedup),
        .capture     (capture),
        .pop_offset  (pop_offset)
    );

    ea_result_reg result_reg_0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .ack        (ack),
        .mode       (mode),
        .addr32     (addr32),
        .window     (window),
        .eax        (eax),
        .ebx        (ebx),
        .esi        (esi),
        .edi        (edi),
        .ea16       (ea16),
        .ea32       (ea32),
        .pop_offset (pop_offset),
        .capture    (capture),
        .address    (address)
    );

endmodule

//--- testbench/tb_ea_ref.svh
// Effective address reference model
`ifndef TB_EA_REF_SVH
`define TB_EA_REF_SVH

logic [`EA_WORD_W-1:0] rng_state = 32'h7abaf10b;

// xorshift32 step
function automatic logic [`EA_WORD_W-1:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Register n in x86 encoding order: eax ecx edx ebx esp ebp esi edi
function automatic logic [`EA_WORD_W-1:0] reg_of(
    input logic [8*`EA_WORD_W-1:0] rf,
    input logic [2:0]              n
);
    return rf[n*`EA_WORD_W +: `EA_WORD_W];
endfunction

// Window bytes: 0 opcode, 1 ModR/M, 2 SIB, disp32 at byte 2 or byte 3
function automatic logic [15:0] ref_ea16(
    input logic [8*`EA_WORD_W-1:0] rf,
    input logic [`EA_WIN_W-1:0]    w
);
    logic [1:0]            mod;
    logic [2:0]            rm;
    logic [15:0]           d16;
    logic [15:0]           sum;
    logic [`EA_WORD_W-1:0] bx;
    logic [`EA_WORD_W-1:0] bp;
    logic [`EA_WORD_W-1:0] si;
    logic [`EA_WORD_W-1:0] di;
    mod = w[15:14];
    rm  = w[10:8];
    d16 = w[31:16];
    bx  = reg_of(rf, 3'd3);
    bp  = reg_of(rf, 3'd5);
    si  = reg_of(rf, 3'd6);
    di  = reg_of(rf, 3'd7);
    if (mod == 2'b00 && rm == 3'b110) begin
        return d16;
    end
    if (!rm[2]) begin
        // BX or BP, plus SI or DI
        sum = (rm[1] ? bp[15:0] : bx[15:0]) + (rm[0] ? di[15:0] : si[15:0]);
    end else begin
        case (rm[1:0])
            2'd0:    sum = si[15:0];
            2'd1:    sum = di[15:0];
            2'd2:    sum = bp[15:0];
            default: sum = bx[15:0];
        endcase
    end
    if (mod == 2'b01) begin
        sum = sum + {{8{d16[7]}}, d16[7:0]};
    end else if (mod == 2'b10) begin
        sum = sum + d16;
    end
    return sum;
endfunction

function automatic logic [`EA_WORD_W-1:0] ref_ea32(
    input logic [8*`EA_WORD_W-1:0] rf,
    input logic [`EA_WIN_W-1:0]    w
);
    logic [1:0]            mod;
    logic [2:0]            rm;
    logic [`EA_WORD_W-1:0] disp;
    logic [`EA_WORD_W-1:0] sum;
    mod = w[15:14];
    rm  = w[10:8];
    if (mod == 2'b00 && rm == 3'b101) begin
        return w[47:16];
    end
    if (rm == 3'b100) begin
        disp = w[55:24];
        sum  = (w[18:16] == 3'b101 && mod == 2'b00) ? disp : reg_of(rf, w[18:16]);
        if (w[21:19] != 3'b100) begin
            sum = sum + (reg_of(rf, w[21:19]) << w[23:22]);
        end
    end else begin
        disp = w[47:16];
        sum  = reg_of(rf, rm);
    end
    if (mod == 2'b01) begin
        sum = sum + {{24{disp[7]}}, disp[7:0]};
    end else if (mod == 2'b10) begin
        sum = sum + disp;
    end
    return sum;
endfunction

// Expected address for one request
function automatic logic [`EA_WORD_W-1:0] ref_address(
    input logic [`EA_MODE_W-1:0]   mode_in,
    input logic                    a32,
    input logic [8*`EA_WORD_W-1:0] rf,
    input logic [`EA_WIN_W-1:0]    w,
    input logic                    big,
    input logic                    speedup,
    input logic [`EA_WORD_W-1:0]   speedup_q
);
    logic [`EA_WORD_W-1:0] value;
    case (mode_in)
        `EA_MODE_MODRM: return a32 ? ref_ea32(rf, w) : {16'h0, ref_ea16(rf, w)};
        `EA_MODE_ESI:   value = reg_of(rf, 3'd6);
        `EA_MODE_EDI:   value = reg_of(rf, 3'd7);
        `EA_MODE_XLAT:  value = reg_of(rf, 3'd3) + {24'h0, rf[7:0]};
        `EA_MODE_MOFFS: value = w[39:8];
        default: begin
            value = reg_of(rf, 3'd4);
            return speedup ? speedup_q : (big ? value : {16'h0, value[15:0]});
        end
    endcase
    return a32 ? value : {16'h0, value[15:0]};
endfunction

// Speedup register after a pop
function automatic logic [`EA_WORD_W-1:0] ref_pop_next(
    input logic                  speedup,
    input logic [`EA_WORD_W-1:0] speedup_q,
    input logic [`EA_WORD_W-1:0] esp_in,
    input logic                  wide_op,
    input logic                  big
);
    logic [`EA_WORD_W-1:0] next;
    next = (speedup ? speedup_q : esp_in) + (wide_op ? 32'd4 : 32'd2);
    return big ? next : {16'h0, next[15:0]};
endfunction

`endif

//--- testbench/tb_read_effective_address.sv
// Effective address unit testbench
`timescale 1ns/1ps
`include "ea_defines.svh"

module tb_read_effective_address;

    localparam int N_HS    = 8;
    localparam int N_M16   = 80;
    localparam int N_M32   = 120;
    localparam int N_STR   = 10;
    localparam int N_POP   = 40;
    localparam int N_TOTAL = N_HS + N_M16 + N_M32 + 8 * N_STR + 2 * N_POP;
    // At most 5 cycles per request, with margin
    localparam int TIMEOUT_CYCLES = (N_TOTAL + 32) * 10;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    req;
    logic                    ack;
    logic [`EA_MODE_W-1:0]   mode;
    logic                    addr32;
    logic                    op32;
    logic                    ss_big;
    logic                    pop_speedup;
    logic [8*`EA_WORD_W-1:0] rf;
    ea_pkg::insn_window_u    window;
    logic [`EA_WORD_W-1:0]   address;
    logic [`EA_WORD_W-1:0]   speedup_model = '0;
    int                      checks_done = 0;
    int                      cycle_count = 0;

    `include "tb_ea_ref.svh"

    read_effective_address dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .ack         (ack),
        .mode        (mode),
        .addr32      (addr32),
        .op32        (op32),
        .ss_big      (ss_big),
        .pop_speedup (pop_speedup),
        .eax         (rf[31:0]),
        .ecx         (rf[63:32]),
        .edx         (rf[95:64]),
        .ebx         (rf[127:96]),
        .esp         (rf[159:128]),
        .ebp         (rf[191:160]),
        .esi         (rf[223:192]),
        .edi         (rf[255:224]),
        .window      (window),
        .address     (address)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error("Timeout: the test did not finish within the cycle limit");
        end
    end

    task automatic randomize_inputs();
        logic [`EA_WORD_W-1:0] hi;
        for (int n = 0; n < 8; n++) begin
            rf[n*`EA_WORD_W +: `EA_WORD_W] = rand32();
        end
        hi     = rand32();
        window = {hi[23:0], rand32()};
    endtask

    // One four-phase transfer with extra hold cycles of back-pressure
    task automatic request(input int hold);
        int                    wait_cycles;
        logic [`EA_WORD_W-1:0] held;
        req = 1'b1;
        @(negedge clk);
        wait_cycles = 1;
        while (!ack) begin
            @(negedge clk);
            wait_cycles++;
        end
        assert (wait_cycles == 1)
        else stop_on_error("ack came later than one cycle after req");
        held = address;
        repeat (hold) begin
            @(negedge clk);
            assert (ack && address == held)
            else stop_on_error($sformatf("FAIL at %0t ns: ack or address moved during hold",
                                         $time));
        end
        req = 1'b0;
        @(negedge clk);
        assert (!ack) else stop_on_error("ack stayed high after req dropped");
    endtask

    // ------------------------------------------------------------------
    // Compare on each rising ack
    // ------------------------------------------------------------------
    initial begin : compare
        logic [`EA_WORD_W-1:0] expected;
        logic                  ack_prev;
        ack_prev = 1'b0;
        forever begin
            @(negedge clk);
            if (ack && !ack_prev) begin
                expected = ref_address(mode, addr32, rf, window, ss_big, pop_speedup,
                                       speedup_model);
                assert (address === expected)
                else stop_on_error($sformatf("FAIL at %0t ns: mode %0d address %h, expected %h",
                                             $time, mode, address, expected));
                if (mode == `EA_MODE_POP) begin
                    speedup_model = ref_pop_next(pop_speedup, speedup_model, rf[159:128],
                                                 op32, ss_big);
                end
                checks_done++;
            end
            ack_prev = ack;
        end
    end

    initial begin : stimulus
        logic [2:0]            str_mode [4];
        logic [`EA_WORD_W-1:0] r;
        str_mode[0] = `EA_MODE_ESI;
        str_mode[1] = `EA_MODE_EDI;
        str_mode[2] = `EA_MODE_XLAT;
        str_mode[3] = `EA_MODE_MOFFS;
        rst_n       = 1'b0;
        req         = 1'b0;
        mode        = `EA_MODE_MODRM;
        addr32      = 1'b0;
        op32        = 1'b0;
        ss_big      = 1'b0;
        pop_speedup = 1'b0;
        rf          = '0;
        window      = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (!ack) else stop_on_error("ack was high after reset");

        // Handshake timing with growing hold
        for (int i = 0; i < N_HS; i++) begin
            randomize_inputs();
            request(i % 4);
        end

        // 16-bit ModR/M, all mod/rm pairs first
        for (int i = 0; i < N_M16; i++) begin
            randomize_inputs();
            if (i < 32) begin
                window.as_modrm.modrm.mod = i[4:3];
                window.as_modrm.modrm.rm  = i[2:0];
            end
            r = rand32();
            request(r[3:2]);
        end

        // 32-bit ModR/M and SIB forms
        addr32 = 1'b1;
        for (int i = 0; i < N_M32; i++) begin
            randomize_inputs();
            if (i < 32) begin
                window.as_modrm.modrm.mod = i[4:3];
                window.as_modrm.modrm.rm  = i[2:0];
            end else begin
                window.as_sib.modrm.rm  = 3'b100;
                window.as_sib.modrm.mod = i[1:0];
                window.as_sib.sib.base  = i[4:2];
                if (i % 5 == 0) begin
                    window.as_sib.sib.index = 3'b100;
                end
            end
            r = rand32();
            request(r[3:2]);
        end

        // String, XLAT and direct offset in both address sizes
        for (int m = 0; m < 4; m++) begin
            for (int s = 0; s < 2; s++) begin
                for (int i = 0; i < N_STR; i++) begin
                    randomize_inputs();
                    mode   = str_mode[m];
                    addr32 = s[0];
                    r      = rand32();
                    request(r[3:2]);
                end
            end
        end

        // Pops near the 64K edge, then the speedup chain
        // XLAT requests inside the chain must leave the speedup register alone
        for (int i = 0; i < 2 * N_POP; i++) begin
            randomize_inputs();
            rf[143:132] = 12'hfff;
            r           = rand32();
            op32        = r[0];
            ss_big      = r[1];
            pop_speedup = (i >= N_POP);
            mode        = (i > N_POP && i % 4 == 0) ? `EA_MODE_XLAT : `EA_MODE_POP;
            request(r[3:2]);
        end

        @(negedge clk);
        if (checks_done == N_TOTAL) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            stop_on_error($sformatf("Only %0d of %0d results were checked",
                                    checks_done, N_TOTAL));
        end
    end

endmodule

//--- sources.f
+incdir+source
+incdir+testbench
source/ea_pkg.sv
source/ea_modrm16.sv
source/ea_sib.sv
source/ea_modrm32.sv
source/ea_stack_pop.sv
source/ea_result_reg.sv
source/read_effective_address.sv
testbench/tb_read_effective_address.sv

//--- Bender.yml
package:
  name: read_effective_address

sources:
  - include_dirs:
      - source
    files:
      - source/ea_pkg.sv
      - source/ea_modrm16.sv
      - source/ea_sib.sv
      - source/ea_modrm32.sv
      - source/ea_stack_pop.sv
      - source/ea_result_reg.sv
      - source/read_effective_address.sv
  - target: test
    include_dirs:
      - source
      - testbench
    files:
      - testbench/tb_read_effective_address.sv
